/* list.f */
+incdir+.
io_pkg.sv
msg_pkg.sv
cmd_parser.sv
io_executor.sv
rsp_builder.sv
cmd_bridge.sv
tb_cmd_bridge.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cmd_bridge \
   -f list.f -o tb_sim || exit 1
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0

/* tb_cmd_bridge.sv */
// Self-checking testbench for the command bridge; compile with list.f and run tb_cmd_bridge
`include "cmd_defs.svh"

module tb_cmd_bridge;
   import msg_pkg::*;

   localparam int N_REQ      = 13;
   // sop, eight words, eop, three cycles of latency and a 32 word slot, with margin
   localparam int REQ_CYCLES = 60;
   localparam int MAX_CYCLES = 16 + REQ_CYCLES * N_REQ;
   // CR then LF
   localparam msg_word_t TERM = 16'h0A0D;

   logic                     clk;
   logic                     i_reset;
   logic                     i_rx_vd;
   msg_word_t                i_rx_data;
   logic                     i_rx_sop;
   logic                     i_rx_eop;
   logic                     o_tx_vd;
   logic [`USB_ADDR_NBIT:0]  o_tx_addr;
   msg_word_t                o_tx_data;
   logic                     o_tx_eop;
   logic [`IO_UNIT_NBIT-1:0] i_io_db;
   logic [`IO_UNIT_NBIT-1:0] o_io_db;
   logic [`IO_UNIT_NBIT-1:0] o_io_dir;
   logic [`IO_BANK_NBIT-1:0] o_io_bank;

   msg_word_t               buf_mem [0:63];
   msg_word_t               req_words[$];
   msg_word_t               data_q[$];
   int                      n_writes;
   int                      cycles = 0;
   int                      eop_cycle;
   int                      first_cycle;
   logic                    rsp_done;
   logic [`USB_ADDR_NBIT:0] eop_addr;
   // Expected IO state, mask dir data
   logic [23:0]             cfg_model;
   logic [7:0]              exp_db;
   logic [7:0]              exp_dir;
   logic [7:0]              exp_bank;

   cmd_bridge u_cmd_bridge (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_rx_vd   (i_rx_vd),
      .i_rx_data (i_rx_data),
      .i_rx_sop  (i_rx_sop),
      .i_rx_eop  (i_rx_eop),
      .o_tx_vd   (o_tx_vd),
      .o_tx_addr (o_tx_addr),
      .o_tx_data (o_tx_data),
      .o_tx_eop  (o_tx_eop),
      .i_io_db   (i_io_db),
      .o_io_db   (o_io_db),
      .o_io_dir  (o_io_dir),
      .o_io_bank (o_io_bank)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Transmit buffer model and watchdog
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the bridge stopped answering", cycles);
         $display("Checks failed");
         $fatal(1);
      end else begin
         if (i_rx_eop)
            eop_cycle = cycles;
         if (o_tx_vd) begin
            if (n_writes == 0)
               first_cycle = cycles;
            buf_mem[o_tx_addr] = o_tx_data;
            n_writes = n_writes + 1;
         end
         if (o_tx_eop) begin
            eop_addr = o_tx_addr;
            rsp_done = 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////
   // Two characters, first one in the low byte
   function automatic msg_word_t text_word(input string s);
      return {s[1], s[0]};
   endfunction

   function automatic logic [7:0] hex_char(input logic [3:0] n, input bit lower);
      if (n < 4'd10)
         return 8'h30 + 8'(n);
      else if (lower)
         return 8'h61 + 8'(n - 4'd10);
      else
         return 8'h41 + 8'(n - 4'd10);
   endfunction

   function automatic msg_word_t hex_word(input logic [7:0] b, input bit lower);
      return {hex_char(b[3:0], lower), hex_char(b[7:4], lower)};
   endfunction

   // Per pin update, masked pins keep their state, input pins read the pad
   function automatic logic [23:0] next_config(input logic [23:0] old,
                                               input logic [23:0] req,
                                               input logic [7:0]  pins);
      logic [23:0] res;
      res[23:16] = req[23:16];
      for (int i = 0; i < 8; i++) begin
         if (req[16+i]) begin
            res[8+i] = old[8+i];
            res[i]   = old[i];
         end else begin
            res[8+i] = req[8+i];
            res[i]   = req[8+i] ? req[i] : pins[i];
         end
      end
      return res;
   endfunction

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp) else begin
         $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   task automatic send_request();
      for (int a = 0; a < 64; a++)
         buf_mem[a] = {10'h2A5, 6'(a)};
      n_writes = 0;
      rsp_done = 1'b0;
      @(negedge clk);
      i_rx_sop = 1'b1;
      @(negedge clk);
      i_rx_sop = 1'b0;
      foreach (req_words[i]) begin
         i_rx_vd   = 1'b1;
         i_rx_data = req_words[i];
         @(negedge clk);
      end
      i_rx_vd  = 1'b0;
      i_rx_eop = 1'b1;
      @(negedge clk);
      i_rx_eop = 1'b0;
   endtask

   task automatic send_io(input msg_word_t mode, input logic [7:0] bank, input bit lower);
      req_words = {text_word("$C"), text_word("02"), mode, hex_word(bank, lower)};
      foreach (data_q[i])
         req_words.push_back(data_q[i]);
      req_words.push_back(TERM);
      send_request();
   endtask

   task automatic wait_response();
      while (!rsp_done)
         @(negedge clk);
   endtask

   task automatic check_io_rsp(input msg_word_t pf, input msg_word_t code,
                               input msg_word_t ch, input logic [23:0] cfg);
      msg_word_t exp [0:31];
      for (int i = 0; i < 32; i++)
         exp[i] = 16'h0000;
      exp[0] = text_word("$C");
      exp[1] = text_word("02");
      exp[2] = pf;
      exp[3] = code;
      exp[4] = ch;
      exp[5] = hex_word(cfg[23:16], 1'b0);
      exp[6] = hex_word(cfg[15:8], 1'b0);
      exp[7] = hex_word(cfg[7:0], 1'b0);
      exp[8] = TERM;
      wait_response();
      check_val(eop_addr, {1'b1, 5'd31}, "IO eop address");
      check_val(n_writes, 31, "IO write count");
      for (int i = 0; i < 31; i++)
         check_val(buf_mem[32+i], exp[i], $sformatf("IO response word %0d", i));
   endtask

   task automatic check_outputs();
      check_val(o_io_db, exp_db, "o_io_db");
      check_val(o_io_dir, exp_dir, "o_io_dir");
      check_val(o_io_bank, exp_bank, "o_io_bank");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [7:0] m;
      logic [7:0] d;
      logic [7:0] v;
      logic [7:0] bank;
      void'($urandom(32'h307c_961a));
      i_reset   = 1'b1;
      i_rx_vd   = 1'b0;
      i_rx_data = '0;
      i_rx_sop  = 1'b0;
      i_rx_eop  = 1'b0;
      i_io_db   = '0;
      cfg_model = '0;
      exp_db    = '0;
      exp_dir   = '0;
      exp_bank  = '0;
      repeat (16) @(negedge clk);
      i_reset = 1'b0;
      check_outputs();

      // Handshake
      req_words = {text_word("$C"), text_word("00"), TERM};
      send_request();
      wait_response();
      check_val(eop_addr, 6'd3, "handshake eop address");
      check_val(n_writes, 4, "handshake write count");
      check_val(buf_mem[0], text_word("$C"), "handshake head");
      check_val(buf_mem[1], text_word("00"), "handshake type");
      check_val(buf_mem[2], text_word("OK"), "handshake pass word");
      check_val(buf_mem[3], text_word("01"), "handshake code");
      check_val(first_cycle - eop_cycle, 4, "handshake latency");

      // Set and exec with random values
      repeat (4) begin
         m       = 8'($urandom);
         d       = 8'($urandom);
         v       = 8'($urandom);
         bank    = 8'($urandom);
         i_io_db = 8'($urandom);
         data_q  = {hex_word(m, 1'b0), hex_word(d, 1'b0), hex_word(v, 1'b0)};
         send_io(text_word("03"), bank, 1'b0);
         cfg_model = next_config(cfg_model, {m, d, v}, i_io_db);
         exp_db    = cfg_model[7:0];
         exp_dir   = cfg_model[15:8];
         exp_bank  = bank;
         check_io_rsp(text_word("OK"), text_word("21"), hex_word(bank, 1'b0), cfg_model);
         check_outputs();
      end

      // Set alone leaves the pads, exec then drives the stored setting
      m       = 8'($urandom);
      d       = 8'($urandom);
      v       = 8'($urandom);
      bank    = 8'($urandom);
      i_io_db = 8'($urandom);
      data_q  = {hex_word(m, 1'b0), hex_word(d, 1'b0), hex_word(v, 1'b0)};
      send_io(text_word("01"), bank, 1'b0);
      cfg_model = next_config(cfg_model, {m, d, v}, i_io_db);
      check_io_rsp(text_word("OK"), text_word("01"), hex_word(bank, 1'b0), cfg_model);
      check_outputs();
      bank = 8'($urandom);
      data_q.delete();
      send_io(text_word("02"), bank, 1'b0);
      exp_db   = cfg_model[7:0];
      exp_dir  = cfg_model[15:8];
      exp_bank = bank;
      check_io_rsp(text_word("OK"), text_word("11"), hex_word(bank, 1'b0), cfg_model);
      check_outputs();

      // Wrong lengths
      data_q = {hex_word(8'h5A, 1'b0)};
      send_io(text_word("02"), 8'h33, 1'b0);
      check_io_rsp(text_word("NG"), text_word("12"), hex_word(8'h33, 1'b0), cfg_model);
      check_outputs();
      data_q = {hex_word(8'h0F, 1'b0), hex_word(8'hF0, 1'b0)};
      send_io(text_word("01"), 8'h44, 1'b0);
      check_io_rsp(text_word("NG"), text_word("02"), hex_word(8'h44, 1'b0), cfg_model);
      check_outputs();

      // Lower case letters in dir, data and bank
      m       = 8'($urandom) & 8'h0F;
      d       = 8'($urandom) | 8'hAA;
      v       = 8'($urandom) | 8'hAA;
      bank    = 8'($urandom) | 8'hAA;
      i_io_db = 8'($urandom);
      data_q  = {hex_word(m, 1'b1), hex_word(d, 1'b1), hex_word(v, 1'b1)};
      send_io(text_word("03"), bank, 1'b1);
      cfg_model = next_config(cfg_model, {m, d, v}, i_io_db);
      exp_db    = cfg_model[7:0];
      exp_dir   = cfg_model[15:8];
      exp_bank  = bank;
      check_io_rsp(text_word("OK"), text_word("21"), hex_word(bank, 1'b1), cfg_model);
      check_outputs();

      // Non-hex character in the dir word
      data_q = {hex_word(8'h00, 1'b0), text_word("G1"), hex_word(8'hFF, 1'b0)};
      send_io(text_word("03"), 8'h12, 1'b0);
      check_io_rsp(text_word("NG"), text_word("23"), hex_word(8'h12, 1'b0), cfg_model);
      check_outputs();

      // Unknown mode answers, unknown type stays silent
      data_q.delete();
      send_io(text_word("09"), 8'h21, 1'b0);
      check_io_rsp(text_word("NG"), text_word("00"), hex_word(8'h21, 1'b0), cfg_model);
      check_outputs();
      req_words = {text_word("$C"), text_word("07"), text_word("03"), hex_word(8'h01, 1'b0),
                   hex_word(8'h00, 1'b0), hex_word(8'hFF, 1'b0), hex_word(8'hFF, 1'b0), TERM};
      send_request();
      repeat (40) @(negedge clk);
      check_val(n_writes, 0, "writes for unknown type");
      check_val(rsp_done, 1'b0, "eop for unknown type");
      check_outputs();

      $display("All checks passed");
      $finish;
   end

endmodule

/* cmd_bridge.sv */
// Top level of the command bridge; connects parser, executor and response builder
`include "cmd_defs.svh"

module cmd_bridge (
   input  logic                     clk,
   input  logic                     i_reset,
   // Receive side
   input  logic                     i_rx_vd,
   input  msg_pkg::msg_word_t       i_rx_data,
   input  logic                     i_rx_sop,
   input  logic                     i_rx_eop,
   // Transmit buffer
   output logic                     o_tx_vd,
   output logic [`USB_ADDR_NBIT:0]  o_tx_addr,
   output msg_pkg::msg_word_t       o_tx_data,
   output logic                     o_tx_eop,
   // IO bank
   input  logic [`IO_UNIT_NBIT-1:0] i_io_db,
   output logic [`IO_UNIT_NBIT-1:0] o_io_db,
   output logic [`IO_UNIT_NBIT-1:0] o_io_dir,
   output logic [`IO_BANK_NBIT-1:0] o_io_bank
);
   import msg_pkg::*;

   req_t req;
   logic req_done;
   rsp_t rsp;
   logic rsp_start;

   cmd_parser u_parser (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_rx_vd    (i_rx_vd),
      .i_rx_data  (i_rx_data),
      .i_rx_sop   (i_rx_sop),
      .i_rx_eop   (i_rx_eop),
      .o_req      (req),
      .o_req_done (req_done)
   );

   io_executor u_exec (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_req       (req),
      .i_req_done  (req_done),
      .i_io_db     (i_io_db),
      .o_rsp       (rsp),
      .o_rsp_start (rsp_start),
      .o_io_db     (o_io_db),
      .o_io_dir    (o_io_dir),
      .o_io_bank   (o_io_bank)
   );

   rsp_builder u_builder (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_rsp       (rsp),
      .i_rsp_start (rsp_start),
      .o_tx_vd     (o_tx_vd),
      .o_tx_addr   (o_tx_addr),
      .o_tx_data   (o_tx_data),
      .o_tx_eop    (o_tx_eop)
   );

endmodule

/* rsp_builder.sv */
// Output stage of the bridge; writes a response record into the transmit buffer word by word
`include "cmd_defs.svh"

module rsp_builder (
   input  logic                      clk,
   input  logic                      i_reset,
   input  msg_pkg::rsp_t             i_rsp,
   input  logic                      i_rsp_start,
   output logic                      o_tx_vd,
   output logic [`USB_ADDR_NBIT:0]   o_tx_addr,
   output msg_pkg::msg_word_t        o_tx_data,
   output logic                      o_tx_eop
);
   import msg_pkg::*;
   import io_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HEAD,
      ST_TYPE,
      ST_PF,
      ST_CODE,
      ST_CHADDR,
      ST_DATA,
      ST_END
   } tx_state_t;

   localparam logic [`USB_ADDR_NBIT-1:0] IDX_LAST = '1;
   localparam msg_word_t                 TERM_WORD = {`MSG_END_N, `MSG_END_R};

   tx_state_t                 state;
   logic [`USB_ADDR_NBIT-1:0] tx_idx;
   logic [`USB_ADDR_NBIT-1:0] idx_inc;
   logic [`USB_ADDR_NBIT-1:0] data_left;
   logic                      term_pend;
   logic                      base;
   io_cfg_t                   cfg_sh;

   assign idx_inc = tx_idx + 1'b1;

   // Handshake slot at base 0, IO slot at base 1
   assign base      = (i_rsp.typ != `MSG_TYPE_HANDSHAKE);
   assign o_tx_addr = {base, tx_idx};

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state    <= ST_IDLE;
         o_tx_vd  <= 1'b0;
         o_tx_eop <= 1'b0;
         tx_idx   <= '0;
      end else begin
         o_tx_vd  <= 1'b0;
         o_tx_eop <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_rsp_start)
                  state <= ST_HEAD;
            end
            ST_HEAD: begin
               o_tx_vd   <= 1'b1;
               tx_idx    <= '0;
               o_tx_data <= `MSG_HEAD;
               state     <= ST_TYPE;
            end
            ST_TYPE: begin
               o_tx_vd   <= 1'b1;
               tx_idx    <= idx_inc;
               o_tx_data <= i_rsp.typ;
               state     <= ST_PF;
            end
            ST_PF: begin
               o_tx_vd   <= 1'b1;
               tx_idx    <= idx_inc;
               o_tx_data <= i_rsp.pf;
               state     <= ST_CODE;
            end
            ST_CODE: begin
               o_tx_vd   <= 1'b1;
               tx_idx    <= idx_inc;
               o_tx_data <= i_rsp.code;
               // Handshake answer ends here
               if (!base) begin
                  o_tx_eop <= 1'b1;
                  state    <= ST_IDLE;
               end else begin
                  state <= ST_CHADDR;
               end
            end
            ST_CHADDR: begin
               o_tx_vd   <= 1'b1;
               tx_idx    <= idx_inc;
               o_tx_data <= i_rsp.ch_word;
               cfg_sh    <= i_rsp.cfg;
               data_left <= `USB_ADDR_NBIT'(`IO_DATA_NUM - 1);
               state     <= ST_DATA;
            end
            ST_DATA: begin
               // Mask, then dir, then data
               o_tx_vd   <= 1'b1;
               tx_idx    <= idx_inc;
               o_tx_data <= byte_to_hex(cfg_sh.mask);
               cfg_sh    <= {cfg_sh.dir, cfg_sh.data, `IO_UNIT_NBIT'(0)};
               data_left <= data_left - 1'b1;
               if (data_left == '0) begin
                  term_pend <= 1'b1;
                  state     <= ST_END;
               end
            end
            ST_END: begin
               tx_idx    <= idx_inc;
               term_pend <= 1'b0;
               o_tx_data <= term_pend ? TERM_WORD : '0;
               // Last slot index closes the record without a write
               if (idx_inc == IDX_LAST) begin
                  o_tx_eop <= 1'b1;
                  state    <= ST_IDLE;
               end else begin
                  o_tx_vd <= 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* io_executor.sv */
// Processing stage of the bridge; judges a request, updates and drives the IO bank, issues a response
`include "cmd_defs.svh"

module io_executor (
   input  logic                     clk,
   input  logic                     i_reset,
   input  msg_pkg::req_t            i_req,
   input  logic                     i_req_done,
   input  logic [`IO_UNIT_NBIT-1:0] i_io_db,
   output msg_pkg::rsp_t            o_rsp,
   output logic                     o_rsp_start,
   output logic [`IO_UNIT_NBIT-1:0] o_io_db,
   output logic [`IO_UNIT_NBIT-1:0] o_io_dir,
   output logic [`IO_BANK_NBIT-1:0] o_io_bank
);
   import msg_pkg::*;
   import io_pkg::*;

   io_cfg_t   cfg;
   io_cfg_t   cfg_new;
   io_cfg_t   cfg_next;
   msg_word_t pf_word;
   msg_word_t code_word;
   logic      is_hs;
   logic      is_io;
   logic      len_set_ok;
   logic      len_exe_ok;
   logic      do_set;
   logic      do_exe;

   assign is_hs      = (i_req.typ == `MSG_TYPE_HANDSHAKE);
   assign is_io      = (i_req.typ == `MSG_TYPE_IOCTRL);
   assign len_set_ok = (i_req.cnt == `USB_ADDR_NBIT'(`IO_DATA_NUM));
   assign len_exe_ok = (i_req.cnt == '0);

   assign cfg_new  = io_apply(cfg, i_req.data, i_io_db);
   assign cfg_next = do_set ? cfg_new : cfg;

   ////////////////////////////////////////////////////////////////////////////
   // Verdict
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      pf_word   = `MSG_FAIL;
      code_word = `MSG_CODE_00;
      do_set    = 1'b0;
      do_exe    = 1'b0;
      if (is_hs) begin
         pf_word   = `MSG_PASS;
         code_word = `MSG_CODE_01;
      end else begin
         case (i_req.mode)
            `MSG_MODE_SETDATA: begin
               // Length is judged before content
               if (!len_set_ok) begin
                  code_word = `MSG_CODE_02;
               end else if (i_req.err) begin
                  code_word = `MSG_CODE_03;
               end else begin
                  pf_word   = `MSG_PASS;
                  code_word = `MSG_CODE_01;
                  do_set    = 1'b1;
               end
            end
            `MSG_MODE_EXEDATA: begin
               code_word = len_exe_ok ? `MSG_CODE_11 : `MSG_CODE_12;
               pf_word   = len_exe_ok ? `MSG_PASS : `MSG_FAIL;
               do_exe    = len_exe_ok;
            end
            `MSG_MODE_SEXDATA: begin
               if (!len_set_ok) begin
                  code_word = `MSG_CODE_22;
               end else if (i_req.err) begin
                  code_word = `MSG_CODE_23;
               end else begin
                  pf_word   = `MSG_PASS;
                  code_word = `MSG_CODE_21;
                  do_set    = 1'b1;
                  do_exe    = 1'b1;
               end
            end
            // Read back only
            `MSG_MODE_RTN: begin
               pf_word   = i_req.err ? `MSG_FAIL : `MSG_PASS;
               code_word = i_req.err ? `MSG_CODE_23 : `MSG_CODE_21;
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // IO bank and response
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (i_reset) begin
         cfg         <= '0;
         o_io_db     <= '0;
         o_io_dir    <= '0;
         o_io_bank   <= '0;
         o_rsp_start <= 1'b0;
      end else begin
         // Unknown types stay silent
         o_rsp_start <= i_req_done && (is_hs || is_io);
         if (i_req_done && is_io) begin
            if (do_set)
               cfg <= cfg_new;
            if (do_exe) begin
               o_io_db   <= cfg_next.data;
               o_io_dir  <= cfg_next.dir;
               o_io_bank <= i_req.bank;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_req_done) begin
         o_rsp.typ     <= i_req.typ;
         o_rsp.pf      <= pf_word;
         o_rsp.code    <= code_word;
         o_rsp.ch_word <= i_req.ch_word;
         o_rsp.cfg     <= cfg_next;
      end
   end

endmodule

/* cmd_parser.sv */
// Input stage of the bridge; walks the received word stream and collects a decoded request
`include "cmd_defs.svh"

module cmd_parser (
   input  logic               clk,
   input  logic               i_reset,
   input  logic               i_rx_vd,
   input  msg_pkg::msg_word_t i_rx_data,
   input  logic               i_rx_sop,
   input  logic               i_rx_eop,
   output msg_pkg::req_t      o_req,
   output logic               o_req_done
);
   import msg_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HEAD,
      ST_TYPE,
      ST_MODE,
      ST_CHADDR,
      ST_DATA,
      ST_END
   } rx_state_t;

   rx_state_t state;
   hex_byte_t hb;
   logic      is_end;

   assign hb = hex_to_byte(i_rx_data);

   // Line end in the first character closes the field list
   assign is_end = (i_rx_data[`USB_DATA_NBIT/2-1:0] == `MSG_END_N) ||
                   (i_rx_data[`USB_DATA_NBIT/2-1:0] == `MSG_END_R);

   ////////////////////////////////////////////////////////////////////////////
   // Field sequencing
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (i_reset) begin
         state      <= ST_IDLE;
         o_req_done <= 1'b0;
      end else begin
         o_req_done <= 1'b0;
         case (state)
            ST_IDLE: ;
            ST_HEAD: begin
               // Anything before the head word is skipped
               if (i_rx_vd && i_rx_data == `MSG_HEAD)
                  state <= ST_TYPE;
            end
            ST_TYPE: begin
               if (i_rx_vd)
                  state <= ST_MODE;
            end
            ST_MODE: begin
               if (i_rx_vd)
                  state <= is_end ? ST_END : ST_CHADDR;
            end
            ST_CHADDR: begin
               if (i_rx_vd)
                  state <= is_end ? ST_END : ST_DATA;
            end
            ST_DATA: begin
               if (i_rx_vd && is_end)
                  state <= ST_END;
            end
            ST_END: ;
            default: state <= ST_IDLE;
         endcase

         // Request is complete once the link frame closes
         if (i_rx_eop && state != ST_IDLE) begin
            o_req_done <= 1'b1;
            state      <= ST_IDLE;
         end
         if (i_rx_sop)
            state <= ST_HEAD;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Request fields
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (i_rx_sop) begin
         o_req <= '0;
      end else if (i_rx_vd) begin
         case (state)
            ST_TYPE: o_req.typ <= i_rx_data;
            ST_MODE: begin
               if (!is_end)
                  o_req.mode <= i_rx_data;
            end
            ST_CHADDR: begin
               if (!is_end) begin
                  o_req.ch_word <= i_rx_data;
                  o_req.bank    <= hb.val;
                  o_req.err     <= o_req.err | hb.err;
               end
            end
            ST_DATA: begin
               // Newest byte enters at the bottom
               if (!is_end) begin
                  o_req.data <= {o_req.data[`MSG_DATA_MAX_NBIT-`USB_DATA_NBIT/2-1:0],
                                 hb.val};
                  o_req.cnt  <= o_req.cnt + 1'b1;
                  o_req.err  <= o_req.err | hb.err;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

/* msg_pkg.sv */
// Message protocol types and hex character conversions shared by all bridge stages
`include "cmd_defs.svh"

package msg_pkg;

   typedef logic [`USB_DATA_NBIT-1:0] msg_word_t;

   // Decoded request as collected by the parser
   typedef struct packed {
      msg_word_t                     typ;
      msg_word_t                     mode;
      msg_word_t                     ch_word;
      logic [`IO_BANK_NBIT-1:0]      bank;
      logic [`MSG_DATA_MAX_NBIT-1:0] data;
      logic [`USB_ADDR_NBIT-1:0]     cnt;
      logic                          err;
   } req_t;

   // Response record handed to the builder
   typedef struct packed {
      msg_word_t       typ;
      msg_word_t       pf;
      msg_word_t       code;
      msg_word_t       ch_word;
      io_pkg::io_cfg_t cfg;
   } rsp_t;

   typedef struct packed {
      logic                         err;
      logic [`USB_DATA_NBIT/2-1:0]  val;
   } hex_byte_t;

   ////////////////////////////////////////////////////////////////////////////
   // Hex helpers
   ////////////////////////////////////////////////////////////////////////////
   // Top bit flags a non-hex character
   function automatic logic [4:0] char_to_nibble(input logic [7:0] c);
      if (c >= "0" && c <= "9")
         return {1'b0, c[3:0]};
      else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f"))
         return {1'b0, c[3:0] + 4'd9};
      else
         return 5'b1_0000;
   endfunction

   function automatic logic [7:0] nibble_to_char(input logic [3:0] n);
      if (n <= 4'd9)
         return {4'h3, n};
      else
         return {4'h4, n - 4'd9};
   endfunction

   // High character arrives in the low half of the word
   function automatic hex_byte_t hex_to_byte(input msg_word_t w);
      logic [4:0] hi;
      logic [4:0] lo;
      hex_byte_t  res;
      hi      = char_to_nibble(w[`USB_DATA_NBIT/2-1:0]);
      lo      = char_to_nibble(w[`USB_DATA_NBIT-1:`USB_DATA_NBIT/2]);
      res.val = {hi[3:0], lo[3:0]};
      res.err = hi[4] | lo[4];
      return res;
   endfunction

   function automatic msg_word_t byte_to_hex(input logic [`USB_DATA_NBIT/2-1:0] b);
      return {nibble_to_char(b[3:0]), nibble_to_char(b[7:4])};
   endfunction

endpackage

/* io_pkg.sv */
// IO bank types and the masked pin update rule, imported by the executor and builder
`include "cmd_defs.svh"

package io_pkg;

   // Mask sits in the top byte, matching the order of the request data words
   typedef struct packed {
      logic [`IO_UNIT_NBIT-1:0] mask;
      logic [`IO_UNIT_NBIT-1:0] dir;
      logic [`IO_UNIT_NBIT-1:0] data;
   } io_cfg_t;

   // dir 1 is output, mask 1 keeps the pin as it was
   function automatic io_cfg_t io_apply(
      input io_cfg_t                        old_cfg,
      input logic [`MSG_DATA_MAX_NBIT-1:0]  req_data,
      input logic [`IO_UNIT_NBIT-1:0]       pins
   );
      io_cfg_t req;
      io_cfg_t res;
      req      = req_data;
      res.mask = req.mask;
      res.dir  = (req.mask & old_cfg.dir) | (~req.mask & req.dir);
      // Input pins take the sampled level
      res.data = (req.mask & old_cfg.data) |
                 (~req.mask & ((req.dir & req.data) | (~req.dir & pins)));
      return res;
   endfunction

endpackage

/* cmd_defs.svh */
// Shared widths, counts and link character codes; include wherever these values are needed
`ifndef CMD_DEFS_SVH
`define CMD_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths and counts
////////////////////////////////////////////////////////////////////////////
// One link word carries two ASCII characters
`define USB_DATA_NBIT     16
// Low buffer address, one response slot is 32 words
`define USB_ADDR_NBIT     5
`define IO_UNIT_NBIT      8
`define IO_BANK_NBIT      8
// Mask, direction and data bytes of a set request
`define MSG_DATA_MAX_NBIT 24
`define IO_DATA_NUM       3

////////////////////////////////////////////////////////////////////////////
// Character codes, first character in the low byte of the word
////////////////////////////////////////////////////////////////////////////
// "$C"
`define MSG_HEAD           16'h4324
`define MSG_TYPE_HANDSHAKE 16'h3030
`define MSG_TYPE_IOCTRL    16'h3230
`define MSG_MODE_SETDATA   16'h3130
`define MSG_MODE_EXEDATA   16'h3230
`define MSG_MODE_SEXDATA   16'h3330
`define MSG_MODE_RTN       16'h3430
// "OK" and "NG"
`define MSG_PASS           16'h4B4F
`define MSG_FAIL           16'h474E

// Status codes
`define MSG_CODE_00        16'h3030
`define MSG_CODE_01        16'h3130
`define MSG_CODE_02        16'h3230
`define MSG_CODE_03        16'h3330
`define MSG_CODE_11        16'h3131
`define MSG_CODE_12        16'h3231
`define MSG_CODE_21        16'h3132
`define MSG_CODE_22        16'h3232
`define MSG_CODE_23        16'h3332

// Line end characters
`define MSG_END_N          8'h0A
`define MSG_END_R          8'h0D

`endif
